/* Bender.yml */
package:
  name: lsu_pipe

sources:
  - files:
      - lsu_pkg.sv
      - lsu_addr_stage.sv
      - lsu_dmem.sv
      - lsu_load_align.sv
      - lsu_writeback.sv
      - lsu_pipe_top.sv
  - target: test
    files:
      - lsu_pipe_chk.sv
      - tb_lsu_pipe.sv

/* lsu_addr_stage.sv */
`timescale 1ns/1ps

module lsu_addr_stage
  import lsu_pkg::*;
(
  input  logic         i_clk,
  input  logic         i_reset_n,
  input  lsu_issue_t   i_issue,
  output lsu_mem_req_t o_mem_req,
  output lsu_stage_t   o_ex1
);

  lsu_ctrl_t             w_ex0_ctrl;
  lsu_issue_t            r_ex1_issue;
  lsu_ctrl_t             r_ex1_ctrl;
  logic [XLEN_W-1:0]     w_ex1_addr;
  logic [BYTE_OFF_W-1:0] w_ex1_lane;
  logic [XLEN_B-1:0]     w_ex1_size_mask;
  logic                  w_ex1_misalign;
  logic                  w_ex1_acc_fault;
  logic                  w_ex1_except;
  lsu_except_t           w_ex1_except_type;

  // --------------------------------------------------
  // EX0 opcode decode
  // --------------------------------------------------
  always_comb begin
    case (i_issue.op)
      OP_LB   : w_ex0_ctrl = '{size: SIZE_B,  is_signed: 1'b1, is_store: 1'b0};
      OP_LH   : w_ex0_ctrl = '{size: SIZE_H,  is_signed: 1'b1, is_store: 1'b0};
      OP_LW   : w_ex0_ctrl = '{size: SIZE_W,  is_signed: 1'b1, is_store: 1'b0};
      OP_LD   : w_ex0_ctrl = '{size: SIZE_DW, is_signed: 1'b1, is_store: 1'b0};
      OP_LBU  : w_ex0_ctrl = '{size: SIZE_B,  is_signed: 1'b0, is_store: 1'b0};
      OP_LHU  : w_ex0_ctrl = '{size: SIZE_H,  is_signed: 1'b0, is_store: 1'b0};
      OP_LWU  : w_ex0_ctrl = '{size: SIZE_W,  is_signed: 1'b0, is_store: 1'b0};
      OP_SB   : w_ex0_ctrl = '{size: SIZE_B,  is_signed: 1'b0, is_store: 1'b1};
      OP_SH   : w_ex0_ctrl = '{size: SIZE_H,  is_signed: 1'b0, is_store: 1'b1};
      OP_SW   : w_ex0_ctrl = '{size: SIZE_W,  is_signed: 1'b0, is_store: 1'b1};
      OP_SD   : w_ex0_ctrl = '{size: SIZE_DW, is_signed: 1'b0, is_store: 1'b1};
      default : w_ex0_ctrl = '{size: SIZE_B,  is_signed: 1'b0, is_store: 1'b0};
    endcase
  end

  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_ex1_issue <= '0;
      r_ex1_ctrl  <= '0;
    end else begin
      r_ex1_issue <= i_issue;
      r_ex1_ctrl  <= w_ex0_ctrl;
    end
  end

  // --------------------------------------------------
  // EX1 address generation and check
  // --------------------------------------------------
  assign w_ex1_addr = r_ex1_issue.base +
                      {{(XLEN_W-OFFSET_W){r_ex1_issue.offset[OFFSET_W-1]}}, r_ex1_issue.offset};
  assign w_ex1_lane = w_ex1_addr[BYTE_OFF_W-1:0];

  always_comb begin
    case (r_ex1_ctrl.size)
      SIZE_H : begin
        w_ex1_size_mask = 8'h03;
        w_ex1_misalign  = w_ex1_lane[0];
      end
      SIZE_W : begin
        w_ex1_size_mask = 8'h0f;
        w_ex1_misalign  = |w_ex1_lane[1:0];
      end
      SIZE_DW : begin
        w_ex1_size_mask = 8'hff;
        w_ex1_misalign  = |w_ex1_lane;
      end
      default : begin
        w_ex1_size_mask = 8'h01;
        w_ex1_misalign  = 1'b0;
      end
    endcase
  end

  assign w_ex1_acc_fault = w_ex1_addr >= XLEN_W'(DMEM_BYTES);
  assign w_ex1_except    = r_ex1_issue.valid & (w_ex1_misalign | w_ex1_acc_fault);

  // Misalign ranks above access fault
  assign w_ex1_except_type = !w_ex1_except    ? EXC_NONE :
                             w_ex1_misalign   ? (r_ex1_ctrl.is_store ? EXC_STORE_MISALIGN :
                                                                       EXC_LOAD_MISALIGN) :
                             r_ex1_ctrl.is_store ? EXC_STORE_ACC_FAULT : EXC_LOAD_ACC_FAULT;

  // Request to data memory, data moved onto its byte lane
  assign o_mem_req.valid   = r_ex1_issue.valid & ~w_ex1_except;
  assign o_mem_req.write   = r_ex1_ctrl.is_store;
  assign o_mem_req.index   = w_ex1_addr[BYTE_OFF_W +: DMEM_INDEX_W];
  assign o_mem_req.byte_en = w_ex1_size_mask << w_ex1_lane;
  assign o_mem_req.wdata   = r_ex1_issue.st_data << {w_ex1_lane, 3'b000};

  assign o_ex1.valid        = r_ex1_issue.valid;
  assign o_ex1.ctrl         = r_ex1_ctrl;
  assign o_ex1.addr         = w_ex1_addr;
  assign o_ex1.rd           = r_ex1_issue.rd;
  assign o_ex1.tag          = r_ex1_issue.tag;
  assign o_ex1.except_valid = w_ex1_except;
  assign o_ex1.except_type  = w_ex1_except_type;

endmodule

/* lsu_dmem.sv */
`timescale 1ns/1ps

module lsu_dmem
  import lsu_pkg::*;
(
  input  logic              i_clk,
  input  logic              i_reset_n,
  input  lsu_mem_req_t      i_req,
  output logic [XLEN_W-1:0] o_rdata
);

  logic [XLEN_W-1:0] r_mem [DMEM_DEPTH];
  logic [XLEN_W-1:0] r_rdata;

  // --------------------------------------------------
  // Byte-masked write
  // --------------------------------------------------
  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      for (int w = 0; w < DMEM_DEPTH; w++) begin
        r_mem[w] <= '0;
      end
    end else if (i_req.valid && i_req.write) begin
      for (int b = 0; b < XLEN_B; b++) begin
        if (i_req.byte_en[b]) begin
          r_mem[i_req.index][b*BYTE_W +: BYTE_W] <= i_req.wdata[b*BYTE_W +: BYTE_W];
        end
      end
    end
  end

  // Registered read, word available one cycle later
  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_rdata <= '0;
    end else if (i_req.valid && !i_req.write) begin
      r_rdata <= r_mem[i_req.index];
    end
  end

  assign o_rdata = r_rdata;

endmodule

/* lsu_load_align.sv */
`timescale 1ns/1ps

module lsu_load_align
  import lsu_pkg::*;
(
  input  logic              i_clk,
  input  logic              i_reset_n,
  input  lsu_stage_t        i_ex1,
  input  logic [XLEN_W-1:0] i_rdata,
  output lsu_stage_t        o_ex2,
  output logic [XLEN_W-1:0] o_ex2_data
);

  lsu_stage_t        r_ex2;
  logic [XLEN_W-1:0] w_shifted;
  logic [XLEN_W-1:0] w_fill;
  logic              w_sign_bit;

  // --------------------------------------------------
  // EX2 register, lines up with the memory read
  // --------------------------------------------------
  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_ex2 <= '0;
    end else begin
      r_ex2 <= i_ex1;
    end
  end

  // Addressed byte moved down to bit 0
  assign w_shifted = i_rdata >> {r_ex2.addr[BYTE_OFF_W-1:0], 3'b000};

  always_comb begin
    case (r_ex2.ctrl.size)
      SIZE_B  : w_sign_bit = w_shifted[BYTE_W-1];
      SIZE_H  : w_sign_bit = w_shifted[2*BYTE_W-1];
      SIZE_W  : w_sign_bit = w_shifted[4*BYTE_W-1];
      default : w_sign_bit = w_shifted[XLEN_W-1];
    endcase
  end

  // Upper bits, sign copies for LB/LH/LW and zeros otherwise
  assign w_fill = {XLEN_W{r_ex2.ctrl.is_signed & w_sign_bit}};

  // --------------------------------------------------
  // Size extension
  // --------------------------------------------------
  always_comb begin
    case (r_ex2.ctrl.size)
      SIZE_B : begin
        o_ex2_data = {w_fill[XLEN_W-1:BYTE_W], w_shifted[BYTE_W-1:0]};
      end
      SIZE_H : begin
        o_ex2_data = {w_fill[XLEN_W-1:2*BYTE_W], w_shifted[2*BYTE_W-1:0]};
      end
      SIZE_W : begin
        o_ex2_data = {w_fill[XLEN_W-1:4*BYTE_W], w_shifted[4*BYTE_W-1:0]};
      end
      default : begin
        o_ex2_data = w_shifted;
      end
    endcase
  end

  assign o_ex2 = r_ex2;

endmodule

/* lsu_pipe_chk.sv */
`timescale 1ns/1ps

module lsu_pipe_chk
  import lsu_pkg::*;
(
  input logic       i_clk,
  input logic       i_reset_n,
  input lsu_issue_t i_issue,
  input lsu_done_t  i_done,
  input lsu_wb_t    i_wb
);

  int fail_count = 0;

  // --------------------------------------------------
  // Port rules
  // --------------------------------------------------
  a_wb_has_done : assert property (@(posedge i_clk) disable iff (!i_reset_n)
    i_wb.valid |-> i_done.valid)
    else begin
      fail_count++;
      $error("write-back without a done report");
    end

  a_except_no_wb : assert property (@(posedge i_clk) disable iff (!i_reset_n)
    (i_done.valid && i_done.except_valid) |-> !i_wb.valid)
    else begin
      fail_count++;
      $error("write-back for an operation with an exception");
    end

  // Issue at edge N drives done after edge N+2, seen here at N+3
  a_done_latency : assert property (@(posedge i_clk) disable iff (!i_reset_n)
    i_done.valid == $past(i_issue.valid, 3))
    else begin
      fail_count++;
      $error("done valid does not follow the issue two edges later");
    end

endmodule

bind lsu_pipe_top lsu_pipe_chk u_chk (
  .i_clk     (i_clk),
  .i_reset_n (i_reset_n),
  .i_issue   (i_issue),
  .i_done    (o_done),
  .i_wb      (o_wb)
);

/* lsu_pipe_top.sv */
`timescale 1ns/1ps

module lsu_pipe_top
  import lsu_pkg::*;
(
  input  logic       i_clk,
  input  logic       i_reset_n,
  input  lsu_issue_t i_issue,
  output lsu_done_t  o_done,
  output lsu_wb_t    o_wb
);

  lsu_mem_req_t      w_mem_req;
  lsu_stage_t        w_ex1;
  logic [XLEN_W-1:0] w_rdata;
  lsu_stage_t        w_ex2;
  logic [XLEN_W-1:0] w_ex2_data;

  // EX0 decode and EX1 address
  lsu_addr_stage u_addr_stage (
    .i_clk     (i_clk),
    .i_reset_n (i_reset_n),
    .i_issue   (i_issue),
    .o_mem_req (w_mem_req),
    .o_ex1     (w_ex1)
  );

  lsu_dmem u_dmem (
    .i_clk     (i_clk),
    .i_reset_n (i_reset_n),
    .i_req     (w_mem_req),
    .o_rdata   (w_rdata)
  );

  // EX2 alignment
  lsu_load_align u_load_align (
    .i_clk      (i_clk),
    .i_reset_n  (i_reset_n),
    .i_ex1      (w_ex1),
    .i_rdata    (w_rdata),
    .o_ex2      (w_ex2),
    .o_ex2_data (w_ex2_data)
  );

  // EX3 done and write-back
  lsu_writeback u_writeback (
    .i_clk      (i_clk),
    .i_reset_n  (i_reset_n),
    .i_ex2      (w_ex2),
    .i_ex2_data (w_ex2_data),
    .o_done     (o_done),
    .o_wb       (o_wb)
  );

endmodule

/* lsu_pkg.sv */
package lsu_pkg;

  // --------------------------------------------------
  // Widths and sizes
  // --------------------------------------------------
  localparam int XLEN_W       = 64;
  localparam int BYTE_W       = 8;
  localparam int XLEN_B       = 8;
  localparam int BYTE_OFF_W   = $clog2(XLEN_B);
  localparam int OFFSET_W     = 12;
  localparam int DMEM_DEPTH   = 512;
  localparam int DMEM_INDEX_W = 9;
  // Valid byte addresses are 0 .. DMEM_BYTES-1
  localparam int DMEM_BYTES   = 4096;
  localparam int RD_W         = 5;
  localparam int TAG_W        = 4;

  // --------------------------------------------------
  // Encodings
  // --------------------------------------------------
  typedef enum logic [3:0] {
    OP_LB  = 4'd0,
    OP_LH  = 4'd1,
    OP_LW  = 4'd2,
    OP_LD  = 4'd3,
    OP_LBU = 4'd4,
    OP_LHU = 4'd5,
    OP_LWU = 4'd6,
    OP_SB  = 4'd7,
    OP_SH  = 4'd8,
    OP_SW  = 4'd9,
    OP_SD  = 4'd10
  } lsu_op_t;

  typedef enum logic [1:0] {
    SIZE_B  = 2'd0,
    SIZE_H  = 2'd1,
    SIZE_W  = 2'd2,
    SIZE_DW = 2'd3
  } lsu_size_t;

  typedef enum logic [2:0] {
    EXC_NONE             = 3'd0,
    EXC_LOAD_MISALIGN    = 3'd1,
    EXC_LOAD_ACC_FAULT   = 3'd2,
    EXC_STORE_MISALIGN   = 3'd3,
    EXC_STORE_ACC_FAULT  = 3'd4
  } lsu_except_t;

  // --------------------------------------------------
  // Bundles between stages
  // --------------------------------------------------
  typedef struct packed {
    logic                valid;
    lsu_op_t             op;
    logic [XLEN_W-1:0]   base;
    logic [OFFSET_W-1:0] offset;
    logic [XLEN_W-1:0]   st_data;
    logic [RD_W-1:0]     rd;
    logic [TAG_W-1:0]    tag;
  } lsu_issue_t;

  typedef struct packed {
    lsu_size_t size;
    logic      is_signed;
    logic      is_store;
  } lsu_ctrl_t;

  typedef struct packed {
    logic                    valid;
    logic                    write;
    logic [DMEM_INDEX_W-1:0] index;
    logic [XLEN_B-1:0]       byte_en;
    logic [XLEN_W-1:0]       wdata;
  } lsu_mem_req_t;

  // Operation state carried from EX1 onwards
  typedef struct packed {
    logic              valid;
    lsu_ctrl_t         ctrl;
    logic [XLEN_W-1:0] addr;
    logic [RD_W-1:0]   rd;
    logic [TAG_W-1:0]  tag;
    logic              except_valid;
    lsu_except_t       except_type;
  } lsu_stage_t;

  typedef struct packed {
    logic              valid;
    logic [TAG_W-1:0]  tag;
    logic              except_valid;
    lsu_except_t       except_type;
    logic [XLEN_W-1:0] tval;
  } lsu_done_t;

  typedef struct packed {
    logic              valid;
    logic [RD_W-1:0]   rd;
    logic [XLEN_W-1:0] data;
  } lsu_wb_t;

endpackage

/* lsu_writeback.sv */
`timescale 1ns/1ps

module lsu_writeback
  import lsu_pkg::*;
(
  input  logic              i_clk,
  input  logic              i_reset_n,
  input  lsu_stage_t        i_ex2,
  input  logic [XLEN_W-1:0] i_ex2_data,
  output lsu_done_t         o_done,
  output lsu_wb_t           o_wb
);

  lsu_stage_t        r_ex3;
  logic [XLEN_W-1:0] r_ex3_data;

  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_ex3      <= '0;
      r_ex3_data <= '0;
    end else begin
      r_ex3      <= i_ex2;
      r_ex3_data <= i_ex2_data;
    end
  end

  // --------------------------------------------------
  // Done report for every operation
  // --------------------------------------------------
  assign o_done.valid        = r_ex3.valid;
  assign o_done.tag          = r_ex3.tag;
  assign o_done.except_valid = r_ex3.except_valid;
  assign o_done.except_type  = r_ex3.except_type;
  assign o_done.tval         = r_ex3.except_valid ? r_ex3.addr : '0;

  // Only loads write back and x0 is never written
  assign o_wb.valid = r_ex3.valid & ~r_ex3.ctrl.is_store & ~r_ex3.except_valid &
                      (r_ex3.rd != '0);
  assign o_wb.rd    = r_ex3.rd;
  assign o_wb.data  = r_ex3_data;

endmodule

/* src.f */
lsu_pkg.sv
lsu_addr_stage.sv
lsu_dmem.sv
lsu_load_align.sv
lsu_writeback.sv
lsu_pipe_top.sv
lsu_pipe_chk.sv
tb_lsu_pipe.sv

/* tb_lsu_pipe.sv */
`timescale 1ns/1ps

module tb_lsu_pipe
  import lsu_pkg::*;
();

  logic       clk;
  logic       reset_n;
  lsu_issue_t issue;
  lsu_done_t  done;
  lsu_wb_t    wb;

  logic [BYTE_W-1:0] mem_model [DMEM_BYTES];
  lsu_done_t         exp_done_q [$];
  lsu_wb_t           exp_wb_q [$];
  lsu_op_t           wide_ops [8] = '{OP_LH, OP_LW, OP_LD, OP_LHU, OP_LWU, OP_SH, OP_SW, OP_SD};
  int                seed = 3;
  int                random_ops = 200;
  int                cycle_count = 0;
  int                timeout_limit;
  int                check_count = 0;
  int                error_count = 0;
  int                tests_run = 0;
  int                tests_bad = 0;
  int                test_start_errors = 0;
  logic [TAG_W-1:0]  next_tag = '0;

  lsu_pipe_top UUT (
    .i_clk     (clk),
    .i_reset_n (reset_n),
    .i_issue   (issue),
    .o_done    (done),
    .o_wb      (wb)
  );

  initial clk = 1'b0;
  always #10 clk = ~clk;

  always @(posedge clk) begin
    cycle_count++;
    if (cycle_count > timeout_limit) begin
      $display("Timeout: the run did not finish within %0d cycles", timeout_limit);
      $display("*** FAILED ***");
      $finish;
    end
  end

  task automatic check_value(input logic [XLEN_W-1:0] actual, input logic [XLEN_W-1:0] expected,
                             input string what);
    check_count++;
    if (actual !== expected) begin
      error_count++;
      $display("[FAIL] %0t ns: %s, got %h, expected %h", $time, what, actual, expected);
    end
  endtask

  function automatic int op_bytes(input lsu_op_t op);
    case (op)
      OP_LB, OP_LBU, OP_SB : return 1;
      OP_LH, OP_LHU, OP_SH : return 2;
      OP_LW, OP_LWU, OP_SW : return 4;
      default              : return 8;
    endcase
  endfunction

  // --------------------------------------------------
  // One cycle, result of the op issued three cycles back
  // --------------------------------------------------
  task automatic step_cycle();
    lsu_done_t exp_d;
    lsu_wb_t   exp_w;
    @(negedge clk);
    if (exp_done_q.size() == 3) begin
      exp_d = exp_done_q.pop_front();
      exp_w = exp_wb_q.pop_front();
      check_value(done.valid, exp_d.valid, "done valid");
      if (exp_d.valid) begin
        check_value(done.tag, exp_d.tag, "done tag");
        check_value(done.except_valid, exp_d.except_valid, "exception flag");
        check_value(done.except_type, exp_d.except_type, "exception type");
        if (exp_d.except_valid) begin
          check_value(done.tval, exp_d.tval, "tval");
        end
      end
      check_value(wb.valid, exp_w.valid, "write-back valid");
      if (exp_w.valid) begin
        check_value(wb.rd, exp_w.rd, "write-back rd");
        check_value(wb.data, exp_w.data, "write-back data");
      end
    end
  endtask

  task automatic idle_cycle();
    step_cycle();
    issue = '0;
    exp_done_q.push_back('0);
    exp_wb_q.push_back('0);
  endtask

  task automatic do_op(input lsu_op_t op, input logic [XLEN_W-1:0] addr,
                       input logic [XLEN_W-1:0] data, input logic [RD_W-1:0] rd);
    lsu_done_t           exp_d;
    lsu_wb_t             exp_w;
    logic [OFFSET_W-1:0] offset;
    logic [XLEN_W-1:0]   load_val;
    int                  nbytes;
    logic                store_op;
    logic                misalign;
    offset   = OFFSET_W'($random(seed));
    nbytes   = op_bytes(op);
    store_op = op inside {OP_SB, OP_SH, OP_SW, OP_SD};
    misalign = (addr % nbytes) != 0;
    exp_d = '0;
    exp_w = '0;
    exp_d.valid = 1'b1;
    exp_d.tag   = next_tag;
    if (misalign || addr >= DMEM_BYTES) begin
      exp_d.except_valid = 1'b1;
      exp_d.tval         = addr;
      // Misalign ranks above access fault
      if (misalign) begin
        exp_d.except_type = store_op ? EXC_STORE_MISALIGN : EXC_LOAD_MISALIGN;
      end else begin
        exp_d.except_type = store_op ? EXC_STORE_ACC_FAULT : EXC_LOAD_ACC_FAULT;
      end
    end else if (store_op) begin
      for (int i = 0; i < nbytes; i++) begin
        mem_model[addr + i] = data[BYTE_W*i +: BYTE_W];
      end
    end else begin
      load_val = '0;
      for (int i = 0; i < nbytes; i++) begin
        load_val[BYTE_W*i +: BYTE_W] = mem_model[addr + i];
      end
      if ((op inside {OP_LB, OP_LH, OP_LW}) && load_val[BYTE_W*nbytes-1]) begin
        for (int b = BYTE_W*nbytes; b < XLEN_W; b++) begin
          load_val[b] = 1'b1;
        end
      end
      exp_w.valid = (rd != '0);
      exp_w.rd    = rd;
      exp_w.data  = load_val;
    end
    step_cycle();
    issue.valid   = 1'b1;
    issue.op      = op;
    issue.offset  = offset;
    issue.base    = addr - {{(XLEN_W-OFFSET_W){offset[OFFSET_W-1]}}, offset};
    issue.st_data = data;
    issue.rd      = rd;
    issue.tag     = next_tag;
    exp_done_q.push_back(exp_d);
    exp_wb_q.push_back(exp_w);
    next_tag++;
  endtask

  task automatic end_test(input string name);
    repeat (3) idle_cycle();
    tests_run++;
    if (error_count != test_start_errors) begin
      tests_bad++;
    end
    $display("Test %-12s finished, %0d mismatches", name, error_count - test_start_errors);
    test_start_errors = error_count;
  endtask

  // --------------------------------------------------
  // Tests
  // --------------------------------------------------
  task automatic test_store_load();
    logic [XLEN_W-1:0] addr;
    for (int k = 0; k < 8; k++) begin
      addr = 64'(({$random(seed)} % 32) * 8);
      // Store then every load back to back
      do_op(lsu_op_t'(OP_SB + k % 4), addr, {$random(seed), $random(seed)}, '0);
      for (int l = 0; l < 7; l++) begin
        do_op(lsu_op_t'(l), addr, '0, RD_W'($random(seed)));
      end
    end
    end_test("store_load");
  endtask

  task automatic test_extend();
    logic [XLEN_W-1:0] pattern [2] = '{64'hf0e0_d0c0_b0a0_9080, 64'h0f1e_2d3c_4b5a_6978};
    for (int p = 0; p < 2; p++) begin
      do_op(OP_SD, 64'd64, pattern[p], '0);
      do_op(OP_LB, 64'd71, '0, 5'd1);
      do_op(OP_LBU, 64'd71, '0, 5'd2);
      do_op(OP_LH, 64'd70, '0, 5'd3);
      do_op(OP_LHU, 64'd70, '0, 5'd4);
      do_op(OP_LW, 64'd68, '0, 5'd5);
      do_op(OP_LWU, 64'd68, '0, 5'd6);
      do_op(OP_LD, 64'd64, '0, 5'd7);
    end
    end_test("extend");
  endtask

  task automatic test_misalign();
    logic [XLEN_W-1:0] addr;
    for (int k = 0; k < 8; k++) begin
      addr = 64'(({$random(seed)} % 32) * 8 + 1 + 2 * ({$random(seed)} % 3));
      do_op(wide_ops[{$random(seed)} % 8], addr, {$random(seed), $random(seed)}, 5'd9);
      // Word must be untouched
      do_op(OP_LD, addr & ~64'd7, '0, 5'd10);
    end
    end_test("misalign");
  endtask

  task automatic test_fault();
    for (int k = 0; k < 6; k++) begin
      do_op(lsu_op_t'({$random(seed)} % 11), 64'(DMEM_BYTES + ({$random(seed)} % 1024) * 8),
            {$random(seed), $random(seed)}, 5'd11);
    end
    for (int k = 0; k < 4; k++) begin
      do_op(wide_ops[k * 2], 64'(2 * DMEM_BYTES + 3), '0, 5'd12);
    end
    end_test("fault");
  endtask

  task automatic test_no_writeback();
    for (int k = 0; k < 6; k++) begin
      do_op(lsu_op_t'(k), 64'(k * 8), '0, '0);
    end
    for (int k = 0; k < 4; k++) begin
      do_op(lsu_op_t'(OP_SB + k), 64'(128 + k * 8), {$random(seed), $random(seed)}, 5'd13);
    end
    end_test("no_wb");
  endtask

  task automatic test_random();
    lsu_op_t           op;
    logic [XLEN_W-1:0] addr;
    int                sel;
    for (int k = 0; k < random_ops; k++) begin
      op  = lsu_op_t'({$random(seed)} % 11);
      sel = {$random(seed)} % 10;
      if (sel == 0) begin
        addr = 64'(({$random(seed)} % 32) * 8 + 1);
      end else if (sel == 1) begin
        addr = 64'(DMEM_BYTES + ({$random(seed)} % 512) * 8);
      end else begin
        addr = 64'({$random(seed)} % 256) & ~64'(op_bytes(op) - 1);
      end
      do_op(op, addr, {$random(seed), $random(seed)}, RD_W'($random(seed)));
    end
    end_test("random");
  endtask

  initial begin
    // Reset, six tests with three drain cycles each, then margin
    timeout_limit = 16 + (64 + 16 + 16 + 10 + 10 + random_ops + 6 * 3) + 100;
    reset_n = 1'b0;
    issue   = '0;
    for (int a = 0; a < DMEM_BYTES; a++) begin
      mem_model[a] = '0;
    end
    repeat (16) @(negedge clk);
    reset_n = 1'b1;
    test_store_load();
    test_extend();
    test_misalign();
    test_fault();
    test_no_writeback();
    test_random();
    $display("Summary: %0d tests, %0d with mismatches, %0d checks, %0d errors, %0d assertion hits",
             tests_run, tests_bad, check_count, error_count, UUT.u_chk.fail_count);
    if (error_count == 0 && UUT.u_chk.fail_count == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule
